//--- design/fetch_core_pkg.sv
`include "fetch_settings.svh"

package fetch_core_pkg;

   typedef enum logic [2:0]
   {
      fs_initialize = 3'd0,
      fs_idle = 3'd1,
      fs_active = 3'd2,
      fs_reload_wait = 3'd3,
      fs_reload_turnaround = 3'd4,
      fs_flush = 3'd5,
      fs_wait_not_full = 3'd6
   } fetch_state_t;

   // one fetched word with its address
   typedef struct packed
   {
      logic [`FETCH_ADDR_WIDTH-1:0] pc;
      logic [31:0] data;
   } fetch_insn_t;

   // registered read of the cache arrays
   typedef struct packed
   {
      logic valid;
      logic [`TAG_BITS-1:0] tag;
      logic [`LINE_BITS-1:0] line;
   } cache_lookup_t;

endpackage

//--- design/fetch_ctrl.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_ctrl
(
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          flush_req,
   output logic                          flush_complete,
   input  logic                          restart_valid,
   input  logic [`FETCH_ADDR_WIDTH-1:0]  restart_pc,
   output logic                          restart_ack,
   output logic [`LG_NUM_SETS-1:0]       rd_index,
   input  fetch_core_pkg::cache_lookup_t lookup,
   output logic                          clear_valid,
   output logic [`LG_NUM_SETS-1:0]       clear_index,
   output logic                          mem_req_valid,
   output fetch_mem_pkg::mem_req_t       mem_req,
   input  logic                          mem_rsp_valid,
   output logic                          fq_push,
   output fetch_core_pkg::fetch_insn_t   fq_insn,
   output logic                          fq_clear,
   input  logic                          fq_full,
   output logic [`COUNTER_WIDTH-1:0]     cache_accesses,
   output logic [`COUNTER_WIDTH-1:0]     cache_hits
);

   localparam int idx_lo = `LG_LINE_BYTES;
   localparam int idx_hi = `LG_LINE_BYTES + `LG_NUM_SETS;
   localparam int word_hi = `LG_LINE_BYTES - 1;
   localparam logic [`FETCH_ADDR_WIDTH-1:0] insn_bytes = 4;

   fetch_core_pkg::fetch_state_t r_state, n_state;
   fetch_mem_pkg::mem_req_t      r_mem_req, n_mem_req;

   // r_pc is the next lookup, r_cache_pc the one being compared
   logic [`FETCH_ADDR_WIDTH-1:0] r_pc, n_pc;
   logic [`FETCH_ADDR_WIDTH-1:0] r_cache_pc, n_cache_pc;
   logic [`FETCH_ADDR_WIDTH-1:0] r_miss_pc, n_miss_pc;
   logic [`LG_NUM_SETS-1:0]      r_cache_idx, t_cache_idx;
   logic                         r_req, n_req;
   logic                         r_restart_req, n_restart_req;
   logic                         r_flush_req, n_flush_req;
   logic                         r_restart_ack, n_restart_ack;
   logic                         r_flush_complete, n_flush_complete;
   logic                         r_mem_req_valid, n_mem_req_valid;
   logic [`COUNTER_WIDTH-1:0]    r_accesses, r_hits;
   logic                         t_hit, t_miss;
   logic                         t_take_flush, t_take_restart;
   logic [31:0]                  t_word;

   assign t_hit = r_req && lookup.valid &&
                  (lookup.tag == r_cache_pc[`FETCH_ADDR_WIDTH-1:idx_hi]);
   assign t_miss = r_req && !t_hit;
   assign t_word = lookup.line[{r_cache_pc[word_hi:2], 5'd0} +: 32];

   assign rd_index = t_cache_idx;
   assign clear_valid = (r_state == fetch_core_pkg::fs_flush);
   assign clear_index = r_cache_idx;
   assign mem_req_valid = r_mem_req_valid;
   assign mem_req = r_mem_req;
   assign fq_insn = '{pc: r_cache_pc, data: t_word};
   assign restart_ack = r_restart_ack;
   assign flush_complete = r_flush_complete;
   assign cache_accesses = r_accesses;
   assign cache_hits = r_hits;

   always_comb
   begin
      n_state = r_state;
      n_pc = r_pc;
      n_cache_pc = r_cache_pc;
      n_miss_pc = r_miss_pc;
      n_mem_req = r_mem_req;
      n_req = 1'b0;
      n_restart_req = r_restart_req | restart_valid;
      n_flush_req = r_flush_req | flush_req;
      n_restart_ack = 1'b0;
      n_flush_complete = 1'b0;
      n_mem_req_valid = 1'b0;
      t_cache_idx = '0;
      t_take_flush = 1'b0;
      t_take_restart = 1'b0;
      fq_push = 1'b0;
      fq_clear = 1'b0;
      case (r_state)
         fetch_core_pkg::fs_initialize:
            n_state = fetch_core_pkg::fs_flush;
         fetch_core_pkg::fs_idle:
            t_take_restart = n_restart_req;
         fetch_core_pkg::fs_active:
         begin
            // issue the next lookup, then act on the compare
            t_cache_idx = r_pc[idx_hi-1:idx_lo];
            n_cache_pc = r_pc;
            n_req = 1'b1;
            n_pc = r_pc + insn_bytes;
            if (n_flush_req)
               t_take_flush = 1'b1;
            else if (n_restart_req)
               t_take_restart = 1'b1;
            else if (t_miss)
            begin
               n_req = 1'b0;
               n_pc = r_pc;
               n_miss_pc = r_cache_pc;
               n_mem_req.addr = {r_cache_pc[`FETCH_ADDR_WIDTH-1:idx_lo], {idx_lo{1'b0}}};
               n_mem_req.opcode = fetch_mem_pkg::mem_lw;
               n_mem_req_valid = 1'b1;
               n_state = fetch_core_pkg::fs_reload_wait;
            end
            else if (t_hit && fq_full)
            begin
               // retry this pc once the queue drains
               n_req = 1'b0;
               n_pc = r_pc;
               n_miss_pc = r_cache_pc;
               n_state = fetch_core_pkg::fs_wait_not_full;
            end
            else if (t_hit)
               fq_push = 1'b1;
         end
         fetch_core_pkg::fs_reload_wait:
         begin
            if (mem_rsp_valid)
               n_state = fetch_core_pkg::fs_reload_turnaround;
         end
         fetch_core_pkg::fs_reload_turnaround, fetch_core_pkg::fs_wait_not_full:
         begin
            if (n_flush_req)
               t_take_flush = 1'b1;
            else if (n_restart_req)
               t_take_restart = 1'b1;
            else if (!fq_full)
            begin
               t_cache_idx = r_miss_pc[idx_hi-1:idx_lo];
               n_cache_pc = r_miss_pc;
               n_req = 1'b1;
               n_state = fetch_core_pkg::fs_active;
            end
         end
         fetch_core_pkg::fs_flush:
         begin
            // one set cleared per cycle
            t_cache_idx = r_cache_idx + 1'b1;
            if (&r_cache_idx)
            begin
               n_flush_complete = 1'b1;
               n_state = fetch_core_pkg::fs_idle;
            end
         end
         default:
            n_state = fetch_core_pkg::fs_idle;
      endcase

      if (t_take_flush)
      begin
         n_flush_req = 1'b0;
         n_req = 1'b0;
         fq_clear = 1'b1;
         t_cache_idx = '0;
         n_state = fetch_core_pkg::fs_flush;
      end
      else if (t_take_restart)
      begin
         n_restart_req = 1'b0;
         n_restart_ack = 1'b1;
         n_req = 1'b0;
         n_pc = restart_pc;
         fq_clear = 1'b1;
         n_state = fetch_core_pkg::fs_active;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= fetch_core_pkg::fs_initialize;
         r_cache_idx <= '0;
         r_req <= 1'b0;
         r_restart_req <= 1'b0;
         r_flush_req <= 1'b0;
         r_restart_ack <= 1'b0;
         r_flush_complete <= 1'b0;
         r_mem_req_valid <= 1'b0;
         r_accesses <= '0;
         r_hits <= '0;
      end
      else
      begin
         r_state <= n_state;
         r_cache_idx <= t_cache_idx;
         r_req <= n_req;
         r_restart_req <= n_restart_req;
         r_flush_req <= n_flush_req;
         r_restart_ack <= n_restart_ack;
         r_flush_complete <= n_flush_complete;
         r_mem_req_valid <= n_mem_req_valid;
         if (r_req)
            r_accesses <= r_accesses + 1'b1;
         if (t_hit)
            r_hits <= r_hits + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      r_pc <= n_pc;
      r_cache_pc <= n_cache_pc;
      r_miss_pc <= n_miss_pc;
      r_mem_req <= n_mem_req;
   end

endmodule

//--- design/fetch_mem_pkg.sv
`include "fetch_settings.svh"

package fetch_mem_pkg;

   // memory opcodes, the fetch side only issues word loads
   typedef enum logic [3:0]
   {
      mem_lb = 4'd0,
      mem_lh = 4'd1,
      mem_lw = 4'd2,
      mem_sb = 4'd3,
      mem_sh = 4'd4,
      mem_sw = 4'd5
   } mem_opcode_t;

   // line aligned reload request
   typedef struct packed
   {
      logic [`FETCH_ADDR_WIDTH-1:0] addr;
      mem_opcode_t opcode;
   } mem_req_t;

endpackage

//--- design/fetch_queue.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_queue
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         push,
   input  fetch_core_pkg::fetch_insn_t  push_insn,
   input  logic                         clear,
   input  logic                         pop,
   output logic                         full,
   output fetch_core_pkg::fetch_insn_t  insn,
   output logic                         insn_valid
);

   localparam int num_entries = 1 << `LG_FQ_ENTRIES;

   fetch_core_pkg::fetch_insn_t entries [num_entries];

   // extra top bit tells full from empty
   logic [`LG_FQ_ENTRIES:0] head_ptr;
   logic [`LG_FQ_ENTRIES:0] tail_ptr;
   logic                    empty;
   logic                    do_push;
   logic                    do_pop;

   assign empty = (head_ptr == tail_ptr);
   assign full = (head_ptr[`LG_FQ_ENTRIES-1:0] == tail_ptr[`LG_FQ_ENTRIES-1:0]) &&
                 (head_ptr[`LG_FQ_ENTRIES] != tail_ptr[`LG_FQ_ENTRIES]);

   assign do_push = push && !full;
   assign do_pop = pop && !empty;

   assign insn = entries[head_ptr[`LG_FQ_ENTRIES-1:0]];
   assign insn_valid = !empty;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         head_ptr <= '0;
         tail_ptr <= '0;
      end
      else if (clear)
      begin
         // clear drops pushes and pops of the same cycle
         head_ptr <= '0;
         tail_ptr <= '0;
      end
      else
      begin
         if (do_push)
            tail_ptr <= tail_ptr + 1'b1;
         if (do_pop)
            head_ptr <= head_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_push && !clear)
         entries[tail_ptr[`LG_FQ_ENTRIES-1:0]] <= push_insn;
   end

endmodule

//--- design/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// pc and memory address width
`define FETCH_ADDR_WIDTH 32

// direct mapped, 16 sets of 16 byte lines
`define LG_NUM_SETS 4
`define LG_LINE_BYTES 4
`define LINE_BITS 128

// tag is what remains above index and offset
`define TAG_BITS (`FETCH_ADDR_WIDTH - `LG_NUM_SETS - `LG_LINE_BYTES)

// eight entry instruction queue
`define LG_FQ_ENTRIES 3

// statistics counters
`define COUNTER_WIDTH 32

`endif

//--- design/icache_arrays.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module icache_arrays
(
   input  logic                           clk,
   input  logic [`LG_NUM_SETS-1:0]        rd_index,
   output fetch_core_pkg::cache_lookup_t  lookup,
   input  logic                           clear_valid,
   input  logic [`LG_NUM_SETS-1:0]        clear_index,
   input  logic                           mem_rsp_valid,
   input  logic [`FETCH_ADDR_WIDTH-1:0]   fill_addr,
   input  logic [`LINE_BITS-1:0]          mem_rsp_data
);

   localparam int num_sets = 1 << `LG_NUM_SETS;
   localparam int idx_lo = `LG_LINE_BYTES;
   localparam int idx_hi = `LG_LINE_BYTES + `LG_NUM_SETS;

   logic [num_sets-1:0]     valid_bits;
   logic [`TAG_BITS-1:0]    tag_mem [num_sets];
   logic [`LINE_BITS-1:0]   line_mem [num_sets];
   logic [`LG_NUM_SETS-1:0] fill_index;

   // set of the outstanding reload
   assign fill_index = fill_addr[idx_hi-1:idx_lo];

   // a reload never overlaps a flush walk
   always_ff @(posedge clk)
   begin
      if (mem_rsp_valid)
         valid_bits[fill_index] <= 1'b1;
      else if (clear_valid)
         valid_bits[clear_index] <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (mem_rsp_valid)
      begin
         tag_mem[fill_index] <= fill_addr[`FETCH_ADDR_WIDTH-1:idx_hi];
         line_mem[fill_index] <= mem_rsp_data;
      end
   end

   // synchronous read, old data on a same cycle write
   always_ff @(posedge clk)
   begin
      lookup.valid <= valid_bits[rd_index];
      lookup.tag <= tag_mem[rd_index];
      lookup.line <= line_mem[rd_index];
   end

endmodule

//--- design/l1i_fetch.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module l1i_fetch
(
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          flush_req,
   output logic                          flush_complete,
   input  logic                          restart_valid,
   input  logic [`FETCH_ADDR_WIDTH-1:0]  restart_pc,
   output logic                          restart_ack,
   output fetch_core_pkg::fetch_insn_t   insn,
   output logic                          insn_valid,
   input  logic                          insn_ack,
   output logic                          mem_req_valid,
   output fetch_mem_pkg::mem_req_t       mem_req,
   input  logic                          mem_rsp_valid,
   input  logic [`LINE_BITS-1:0]         mem_rsp_data,
   output logic [`COUNTER_WIDTH-1:0]     cache_accesses,
   output logic [`COUNTER_WIDTH-1:0]     cache_hits
);

   logic [`LG_NUM_SETS-1:0]       rd_index;
   fetch_core_pkg::cache_lookup_t lookup;
   logic                          clear_valid;
   logic [`LG_NUM_SETS-1:0]       clear_index;
   logic                          fq_push;
   fetch_core_pkg::fetch_insn_t   fq_insn;
   logic                          fq_clear;
   logic                          fq_full;

   fetch_ctrl i_ctrl
   (
      .clk            (clk),
      .reset          (reset),
      .flush_req      (flush_req),
      .flush_complete (flush_complete),
      .restart_valid  (restart_valid),
      .restart_pc     (restart_pc),
      .restart_ack    (restart_ack),
      .rd_index       (rd_index),
      .lookup         (lookup),
      .clear_valid    (clear_valid),
      .clear_index    (clear_index),
      .mem_req_valid  (mem_req_valid),
      .mem_req        (mem_req),
      .mem_rsp_valid  (mem_rsp_valid),
      .fq_push        (fq_push),
      .fq_insn        (fq_insn),
      .fq_clear       (fq_clear),
      .fq_full        (fq_full),
      .cache_accesses (cache_accesses),
      .cache_hits     (cache_hits)
   );

   // fills land at the set of the registered request
   icache_arrays i_arrays
   (
      .clk           (clk),
      .rd_index      (rd_index),
      .lookup        (lookup),
      .clear_valid   (clear_valid),
      .clear_index   (clear_index),
      .mem_rsp_valid (mem_rsp_valid),
      .fill_addr     (mem_req.addr),
      .mem_rsp_data  (mem_rsp_data)
   );

   fetch_queue i_queue
   (
      .clk        (clk),
      .reset      (reset),
      .push       (fq_push),
      .push_insn  (fq_insn),
      .clear      (fq_clear),
      .pop        (insn_ack),
      .full       (fq_full),
      .insn       (insn),
      .insn_valid (insn_valid)
   );

endmodule

//--- dv/l1i_fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module l1i_fetch_tb;

   localparam int clk_period = 100;
   localparam logic [31:0] data_mask = 32'hA5A5_0000;
   localparam int pass_one_words = 40;
   localparam int pass_two_words = 24;
   localparam int stall_rounds = 3;
   localparam int stall_cycles = 40;
   localparam int drain_words = 16;
   localparam int flush_words = 12;
   localparam int idle_cycles = 20;
   localparam int refetch_words = 8;
   localparam int handshake_limit = 64;
   localparam int test_cycles = 2 * handshake_limit + pass_one_words + pass_two_words +
                                stall_rounds * (stall_cycles + drain_words) +
                                flush_words + idle_cycles + refetch_words;

   logic clk, reset;
   logic flush_req, flush_complete, restart_valid, restart_ack;
   logic [`FETCH_ADDR_WIDTH-1:0] restart_pc;
   fetch_core_pkg::fetch_insn_t insn;
   logic insn_valid, insn_ack;
   logic mem_req_valid, mem_rsp_valid;
   fetch_mem_pkg::mem_req_t mem_req;
   logic [`LINE_BITS-1:0] mem_rsp_data;
   logic [`COUNTER_WIDTH-1:0] cache_accesses, cache_hits;

   // scoreboard state, updated on the edges the assertions sample
   logic [`FETCH_ADDR_WIDTH-1:0] expected_pc, refetch_addr;
   logic [`COUNTER_WIDTH-1:0] last_accesses, last_hits;
   logic seen_first_ack, flushed_idle, last_flush_complete, last_restart_ack;
   logic no_miss_expected, watch_refetch;
   int init_flush_count, pop_count, req_count, refetch_count;
   int error_count = 0;

   tb_clock i_clock (.clk(clk), .reset(reset));

   l1i_fetch i_dut (.*);

   task automatic flag_mismatch(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
      error_count++;
      $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
   endtask

   task automatic flag_problem(input string what);
      error_count++;
      $display("error: %s", what);
   endtask

   task automatic finish_run();
      $display("errors: %0d, checked pops: %0d, reload requests: %0d",
               error_count, pop_count, req_count);
      if (error_count == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   endtask

   // word i of a line sits at bits 32*i and holds its byte address xor mask
   function automatic logic [`LINE_BITS-1:0] line_for(input logic [`FETCH_ADDR_WIDTH-1:0] addr);
      logic [`LINE_BITS-1:0] line;
      for (int i = 0; i < `LINE_BITS / 32; i++)
         line[32*i +: 32] = (addr + 32'(4 * i)) ^ data_mask;
      return line;
   endfunction

   always @(posedge clk)
   begin
      if (reset)
      begin
         expected_pc <= '0;
         refetch_addr <= '0;
         last_accesses <= '0;
         last_hits <= '0;
         seen_first_ack <= 1'b0;
         flushed_idle <= 1'b0;
         last_flush_complete <= 1'b0;
         last_restart_ack <= 1'b0;
         init_flush_count <= 0;
         pop_count <= 0;
         req_count <= 0;
         refetch_count <= 0;
      end
      else
      begin
         // next pc follows the last pop, or the restart target
         if (restart_ack)
            expected_pc <= restart_pc;
         else if (insn_valid && insn_ack)
            expected_pc <= expected_pc + 32'd4;
         if (insn_valid && insn_ack)
            pop_count <= pop_count + 1;
         if (restart_ack)
            seen_first_ack <= 1'b1;
         if (flush_complete && !seen_first_ack)
            init_flush_count <= init_flush_count + 1;
         if (flush_complete)
            flushed_idle <= 1'b1;
         else if (restart_ack)
            flushed_idle <= 1'b0;
         if (mem_req_valid)
            req_count <= req_count + 1;
         if (mem_req_valid && watch_refetch)
         begin
            if (refetch_count == 0)
               refetch_addr <= mem_req.addr;
            refetch_count <= refetch_count + 1;
         end
         last_flush_complete <= flush_complete;
         last_restart_ack <= restart_ack;
         last_accesses <= cache_accesses;
         last_hits <= cache_hits;
      end
   end

   no_early_insn: assert property (@(posedge clk) disable iff (reset)
      !seen_first_ack |-> !insn_valid)
      else flag_problem("insn_valid rose before the first restart_ack");
   one_reset_flush: assert property (@(posedge clk) disable iff (reset)
      restart_ack && !seen_first_ack |-> init_flush_count == 1)
      else flag_mismatch("reset_flush_count", 1, $sampled(init_flush_count));
   flush_pulse: assert property (@(posedge clk) disable iff (reset)
      flush_complete |-> !last_flush_complete)
      else flag_problem("flush_complete stayed high for more than one cycle");
   restart_pulse: assert property (@(posedge clk) disable iff (reset)
      restart_ack |-> !last_restart_ack)
      else flag_problem("restart_ack stayed high for more than one cycle");
   pop_data: assert property (@(posedge clk) disable iff (reset)
      insn_valid && insn_ack |-> insn.data == (insn.pc ^ data_mask))
      else flag_mismatch("insn_data", $sampled(insn.pc) ^ data_mask, $sampled(insn.data));
   pop_pc: assert property (@(posedge clk) disable iff (reset)
      insn_valid && insn_ack |-> insn.pc == expected_pc)
      else flag_mismatch("insn_pc", $sampled(expected_pc), $sampled(insn.pc));
   req_aligned: assert property (@(posedge clk) disable iff (reset)
      mem_req_valid |-> mem_req.addr[`LG_LINE_BYTES-1:0] == '0)
      else flag_mismatch("mem_req_addr", $sampled(mem_req.addr) & ~32'hF, $sampled(mem_req.addr));
   req_opcode: assert property (@(posedge clk) disable iff (reset)
      mem_req_valid |-> mem_req.opcode == fetch_mem_pkg::mem_lw)
      else flag_mismatch("mem_req_opcode", fetch_mem_pkg::mem_lw, $sampled(mem_req.opcode));
   no_miss_on_cached: assert property (@(posedge clk) disable iff (reset)
      mem_req_valid |-> !no_miss_expected)
      else flag_problem("reload requested during the second pass over cached code");
   no_req_when_flushed: assert property (@(posedge clk) disable iff (reset)
      mem_req_valid |-> !flushed_idle)
      else flag_problem("reload requested between flush_complete and restart_ack");
   hits_bounded: assert property (@(posedge clk) disable iff (reset)
      cache_hits <= cache_accesses)
      else flag_mismatch("hits_vs_accesses", $sampled(cache_accesses), $sampled(cache_hits));
   counters_grow: assert property (@(posedge clk) disable iff (reset)
      cache_accesses >= last_accesses && cache_hits >= last_hits)
      else flag_problem("a statistics counter went backwards");

   // memory answers each request once, 1 to 6 cycles later
   initial
   begin
      logic [`FETCH_ADDR_WIDTH-1:0] line_addr;
      int latency;
      mem_rsp_valid = 1'b0;
      mem_rsp_data = '0;
      forever
      begin
         @(posedge clk);
         #1;
         mem_rsp_valid = 1'b0;
         if (mem_req_valid && !reset)
         begin
            line_addr = mem_req.addr;
            latency = 1 + int'($urandom % 6);
            repeat (latency) @(posedge clk);
            #1;
            mem_rsp_data = line_for(line_addr);
            mem_rsp_valid = 1'b1;
         end
      end
   end

   task automatic pop_words(input int count, input int ack_pct);
      int target;
      target = pop_count + count;
      while (pop_count < target)
      begin
         insn_ack = int'($urandom % 100) < ack_pct;
         @(posedge clk);
         #1;
      end
      insn_ack = 1'b0;
   endtask

   task automatic restart_at(input logic [`FETCH_ADDR_WIDTH-1:0] pc);
      int waited;
      restart_pc = pc;
      restart_valid = 1'b1;
      @(posedge clk);
      #1;
      restart_valid = 1'b0;
      waited = 0;
      while (!restart_ack && waited < handshake_limit)
      begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (!restart_ack)
         flag_problem($sformatf("restart to %h was never acknowledged", pc));
   endtask

   task automatic wait_flush_done();
      int waited;
      waited = 0;
      while (!flush_complete && waited < handshake_limit)
      begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (!flush_complete)
         flag_problem("flush_complete never arrived");
   endtask

   initial
   begin
      #(test_cycles * 20 * clk_period);
      flag_problem($sformatf("watchdog expired after %0d cycles", test_cycles * 20));
      finish_run();
   end

   initial
   begin
      logic [`COUNTER_WIDTH-1:0] hits_before;
      void'($urandom(32'h2796_e2c0));
      flush_req = 1'b0;
      restart_valid = 1'b0;
      restart_pc = '0;
      insn_ack = 1'b0;
      no_miss_expected = 1'b0;
      watch_refetch = 1'b0;
      @(negedge reset);
      wait_flush_done();

      // first pass fills the cache, second one must hit throughout
      restart_at(32'h0000_1000);
      pop_words(pass_one_words, 70);
      restart_at(32'h0000_1000);
      no_miss_expected = 1'b1;
      hits_before = cache_hits;
      pop_words(pass_two_words, 70);
      no_miss_expected = 1'b0;
      // every word of the second pass was pushed on a hit
      second_pass_hits: assert (cache_hits - hits_before >= pass_two_words)
         else flag_mismatch("second_pass_hits", pass_two_words, cache_hits - hits_before);

      // consumer stalls long enough to fill the queue
      restart_at(32'h0000_2000);
      repeat (stall_rounds)
      begin
         repeat (stall_cycles) @(posedge clk);
         #1;
         pop_words(drain_words, 100);
      end

      // flush mid stream, stay idle, then the same lines come back
      restart_at(32'h0000_1000);
      pop_words(flush_words, 70);
      flush_req = 1'b1;
      @(posedge clk);
      #1;
      flush_req = 1'b0;
      wait_flush_done();
      repeat (idle_cycles) @(posedge clk);
      #1;
      watch_refetch = 1'b1;
      restart_at(32'h0000_1000);
      pop_words(refetch_words, 70);
      refetch_first: assert (refetch_addr == 32'h0000_1000)
         else flag_mismatch("refetch_addr", 32'h0000_1000, refetch_addr);
      refetch_lines: assert (refetch_count >= 2)
         else flag_mismatch("refetch_count", 2, refetch_count);
      finish_run();
   end

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
(
   output logic clk,
   output logic reset
);

   localparam int half_period = 50;

   initial
   begin
      clk = 1'b0;
      forever #half_period clk = ~clk;
   end

   // two rising edges in reset, released just after the second
   initial
   begin
      reset = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
   end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fetch testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module l1i_fetch_tb \
   -f sources.f -o sim_top > "$build_log" 2>&1
if [ $? -ne 0 ]; then
   cat "$build_log"
   echo "build failed"
   exit 1
fi

./obj_dir/sim_top > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Some tests failed" "$sim_log"; then
   exit 1
fi
exit 0

//--- sources.f
+incdir+design
design/fetch_mem_pkg.sv
design/fetch_core_pkg.sv
design/icache_arrays.sv
design/fetch_queue.sv
design/fetch_ctrl.sv
design/l1i_fetch.sv
dv/tb_clock.sv
dv/l1i_fetch_tb.sv
